// File: customInstructionUnit.f
+incdir+.
ciPkg.sv
pixelPkg.sv
resetSequencer.sv
swapByteIse.sv
rgb565GrayIse.sv
delayIse.sv
cycleProfiler.sv
customInstructionUnit.sv
tbClockGen.sv
customInstructionUnitTb.sv

// File: customInstructionUnitTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module customInstructionUnitTb;

  localparam int SWAP_WORDS = 8;
  localparam int GRAY_PIXELS = 8;
  localparam int PROFILE_ROUNDS = 5;
  localparam int RELEASE_CYCLES = 16;
  // longest possible length of each test in cycles.
  localparam int TEST_CYCLES = 30 + 4 * SWAP_WORDS + 2 * GRAY_PIXELS + 50
                               + 18 * PROFILE_ROUNDS + 60;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic               s_systemClock;
  logic               s_pllLocked;
  logic               ready;
  ciPkg::ciRequest_t  ciRequest;
  ciPkg::ciResponse_t ciResponse;
  logic               expDone;
  logic [31:0]        expResult;
  logic [15:0]        lfsrState;
  int                 lockEdges;
  int                 failCount;
  int                 failsBefore;
  int                 testsRun;
  int                 testsFailed;
  int                 delayMicros [3] = '{0, 1, 3};
  string              testName;

  tbClockGen tbClockGen_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked)
  );

  customInstructionUnit customInstructionUnit_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ciRequest    (ciRequest),
    .ciResponse   (ciResponse),
    .ready        (ready)
  );

  // clock edges seen since lock.
  always @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockEdges <= 0;
    end else if (lockEdges < 31) begin
      lockEdges <= lockEdges + 1;
    end
  end

  readyTiming : assert property (
    @(posedge s_systemClock) ready == (lockEdges >= RELEASE_CYCLES)
  ) else begin
    failCount++;
    $display("error %s: expected ready %0b, actual ready %0b", testName,
             $sampled(lockEdges) >= RELEASE_CYCLES, $sampled(ready));
  end

  responseMatches : assert property (
    @(posedge s_systemClock)
      ciResponse.done == expDone && (!expDone || ciResponse.result == expResult)
  ) else begin
    failCount++;
    $display("error %s: expected done %0b result %h, actual done %0b result %h", testName,
             $sampled(expDone), $sampled(expResult), $sampled(ciResponse.done),
             $sampled(ciResponse.result));
  end

  // x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  function automatic logic [31:0] swapExpected(input logic [31:0] word, input logic halves);
    if (halves) begin
      return {word[15:0], word[31:16]};
    end
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  function automatic logic [31:0] grayExpected(input logic [15:0] pixel);
    int red;
    int green;
    int blue;
    red = int'(pixel[15:11]) * 8;
    green = int'(pixel[10:5]) * 4;
    blue = int'(pixel[4:0]) * 8;
    return 32'((red * 54 + green * 183 + blue * 19) / 256);
  endfunction

  task automatic driveCycle(input logic start, input logic [7:0] opcode,
                            input logic [31:0] dataA, input logic [31:0] dataB,
                            input logic expectDone, input logic [31:0] expectResult);
    @(negedge s_systemClock);
    ciRequest.start = start;
    ciRequest.opcode = opcode;
    ciRequest.dataA = dataA;
    ciRequest.dataB = dataB;
    expDone = expectDone;
    expResult = expectResult;
  endtask

  // opcode and data stay held while waiting.
  task automatic holdIdle(input int cycles);
    repeat (cycles) begin
      driveCycle(1'b0, ciRequest.opcode, ciRequest.dataA, ciRequest.dataB, 1'b0, 32'd0);
    end
  endtask

  task automatic openTest(input string name);
    testName = name;
    failsBefore = failCount;
  endtask

  task automatic closeTest();
    @(negedge s_systemClock);  // last check has been made.
    testsRun++;
    if (failCount != failsBefore) begin
      testsFailed++;
    end
    $display("test %s finished, %0d failed checks", testName, failCount - failsBefore);
  endtask

  initial begin
    logic [31:0] word;
    int          cycles;
    int          d;
    int          k;
    int          prevCount;
    ciRequest = '0;
    expDone = 1'b0;
    expResult = '0;
    lfsrState = 16'd18939;
    failCount = 0;
    failsBefore = 0;
    testsRun = 0;
    testsFailed = 0;
    openTest("reset");
    while (ready !== 1'b1) begin
      @(negedge s_systemClock);
    end
    holdIdle(4);
    closeTest();

    openTest("byteSwap");
    for (int mode = 0; mode < 2; mode++) begin
      for (int n = 0; n < SWAP_WORDS; n++) begin
        word = randomBits(32);
        driveCycle(1'b1, `SWAP_BYTE_CI_ID, word, 32'(mode), 1'b1,
                   swapExpected(word, mode[0]));
        holdIdle(1);
      end
    end
    closeTest();

    openTest("grayscale");
    for (int n = 0; n < GRAY_PIXELS; n++) begin
      word = randomBits(16);
      driveCycle(1'b1, `GRAY_CI_ID, word, 32'd0, 1'b1, grayExpected(word[15:0]));
      holdIdle(1);
    end
    closeTest();

    openTest("delay");
    for (int n = 0; n < 3; n++) begin
      cycles = (delayMicros[n] == 0) ? 1 : delayMicros[n] * `CYCLES_PER_MICROSECOND;
      driveCycle(1'b1, `DELAY_CI_ID, delayMicros[n], 32'd0, 1'b0, 32'd0);
      holdIdle(cycles - 1);
      driveCycle(1'b0, `DELAY_CI_ID, delayMicros[n], 32'd0, 1'b1, 32'd0);
      holdIdle(1);
    end
    closeTest();

    openTest("profiler");
    prevCount = 0;  // disabled since reset.
    for (int n = 0; n < PROFILE_ROUNDS; n++) begin
      d = randomBits(4) + 1;
      driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd3, 1'b1, prevCount);
      holdIdle(d - 1);
      driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd1, 1'b1, d - 1);
      prevCount = d;  // still enabled, one more step before the next read.
    end
    d = randomBits(4) + 1;
    k = randomBits(3) + 1;
    driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd3, 1'b1, prevCount);
    holdIdle(d - 1);
    driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd0, 1'b1, d - 1);
    holdIdle(k);
    driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd0, 1'b1, d);  // frozen after the stop edge.
    holdIdle(k);
    driveCycle(1'b1, `PROFILE_CI_ID, 32'd0, 32'd0, 1'b1, d);
    holdIdle(1);
    closeTest();

    $display("tests run %0d, tests failed %0d, failed checks %0d", testsRun, testsFailed,
             failCount);
    if (failCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge s_systemClock);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
  output logic s_systemClock,
  output logic s_pllLocked
);

  localparam int HALF_PERIOD = 50;  // 100 ns clock.
  localparam int RESET_CYCLES = 3;

  initial begin
    s_systemClock = 1'b0;
    forever #HALF_PERIOD s_systemClock = ~s_systemClock;
  end

  initial begin
    s_pllLocked = 1'b1;
    #(HALF_PERIOD / 2) s_pllLocked = 1'b0;  // clean falling edge at power-on.
    repeat (RESET_CYCLES) @(posedge s_systemClock);
    @(negedge s_systemClock);
    s_pllLocked = 1'b1;  // lock comes on a falling edge.
  end

endmodule

`default_nettype wire

// File: customInstructionUnit.sv
`timescale 1ns/1ps
`default_nettype none

module customInstructionUnit (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  input  ciPkg::ciRequest_t  ciRequest,
  output ciPkg::ciResponse_t ciResponse,
  output logic               ready
);

  ciPkg::ciResponse_t swapResponse;
  ciPkg::ciResponse_t grayResponse;
  ciPkg::ciResponse_t delayResponse;
  ciPkg::ciResponse_t profileResponse;

  resetSequencer resetSequencer_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ready        (ready)
  );

  swapByteIse swapByteIse_i (
    .ciRequest (ciRequest),
    .ciResponse(swapResponse)
  );

  rgb565GrayIse rgb565GrayIse_i (
    .ciRequest (ciRequest),
    .ciResponse(grayResponse)
  );

  delayIse delayIse_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ready        (ready),
    .ciRequest    (ciRequest),
    .ciResponse   (delayResponse)
  );

  cycleProfiler cycleProfiler_i (
    .s_systemClock(s_systemClock),
    .s_pllLocked  (s_pllLocked),
    .ready        (ready),
    .ciRequest    (ciRequest),
    .ciResponse   (profileResponse)
  );

  // idle units drive zero, so OR acts as the answer mux.
  assign ciResponse = swapResponse | grayResponse | delayResponse | profileResponse;

  atMostOneDone : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      $onehot0({swapResponse.done, grayResponse.done, delayResponse.done,
                profileResponse.done})
  );

endmodule

`default_nettype wire

// File: cycleProfiler.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module cycleProfiler (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  input  logic               ready,
  input  ciPkg::ciRequest_t  ciRequest,
  output ciPkg::ciResponse_t ciResponse
);

  logic        hit;
  logic        countEnable;
  logic [31:0] cycleCount;

  assign hit = ciRequest.start && (ciRequest.opcode == `PROFILE_CI_ID);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      countEnable <= 1'b0;
      cycleCount  <= '0;
    end else if (!ready) begin
      countEnable <= 1'b0;
      cycleCount  <= '0;
    end else begin
      if (hit) begin
        countEnable <= ciRequest.dataB[0];
      end
      if (hit && ciRequest.dataB[1]) begin
        cycleCount <= '0;  // clear wins over the increment.
      end else if (countEnable) begin
        cycleCount <= cycleCount + 1'b1;
      end
    end
  end

  // the read returns the count from before this edge.
  assign ciResponse.done = hit;
  assign ciResponse.result = hit ? cycleCount : '0;

endmodule

`default_nettype wire

// File: delayIse.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module delayIse (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  input  logic               ready,
  input  ciPkg::ciRequest_t  ciRequest,
  output ciPkg::ciResponse_t ciResponse
);

  logic        hit;
  logic        busy;
  logic        lastCycle;
  logic [35:0] requestedCycles;
  logic [35:0] loadCount;
  logic [35:0] cycleCount;

  assign hit = ciRequest.start && (ciRequest.opcode == `DELAY_CI_ID);

  // 32-bit microseconds times the clock rate needs 36 bits.
  assign requestedCycles = {4'd0, ciRequest.dataA} * 36'(`CYCLES_PER_MICROSECOND);
  assign loadCount = (requestedCycles == '0) ? 36'd1 : requestedCycles;  // minimum one cycle.

  assign lastCycle = busy && (cycleCount == 36'd1);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy       <= 1'b0;
      cycleCount <= '0;
    end else if (!ready) begin
      busy       <= 1'b0;
      cycleCount <= '0;
    end else if (hit) begin
      busy       <= 1'b1;
      cycleCount <= loadCount;
    end else if (lastCycle) begin
      busy       <= 1'b0;
      cycleCount <= '0;
    end else if (busy) begin
      cycleCount <= cycleCount - 1'b1;
    end
  end

  assign ciResponse.done = lastCycle;
  assign ciResponse.result = '0;  // a delay returns nothing.

  // the processor is stalled on this instruction until done.
  noStartWhileBusy : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      busy |-> !hit
  );

endmodule

`default_nettype wire

// File: rgb565GrayIse.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module rgb565GrayIse (
  input  ciPkg::ciRequest_t  ciRequest,
  output ciPkg::ciResponse_t ciResponse
);

  logic              hit;
  pixelPkg::rgb565_t pixel;
  logic [7:0]        red8;
  logic [7:0]        green8;
  logic [7:0]        blue8;
  logic [15:0]       weightedSum;
  pixelPkg::gray_t   gray;

  assign hit = ciRequest.start && (ciRequest.opcode == `GRAY_CI_ID);
  assign pixel = ciRequest.dataA[15:0];

  // widen each channel to 8 bits.
  assign red8 = {pixel.red, 3'b000};
  assign green8 = {pixel.green, 2'b00};
  assign blue8 = {pixel.blue, 3'b000};

  // weights sum to 256, so the total never exceeds 16 bits.
  assign weightedSum = red8 * 16'd54 + green8 * 16'd183 + blue8 * 16'd19;
  assign gray = weightedSum[15:8];

  assign ciResponse.done = hit;
  assign ciResponse.result = hit ? {24'd0, gray} : '0;

endmodule

`default_nettype wire

// File: swapByteIse.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module swapByteIse (
  input  ciPkg::ciRequest_t  ciRequest,
  output ciPkg::ciResponse_t ciResponse
);

  logic           hit;
  ciPkg::ciWord_u wordIn;
  ciPkg::ciWord_u wordOut;

  assign hit = ciRequest.start && (ciRequest.opcode == `SWAP_BYTE_CI_ID);
  assign wordIn = ciRequest.dataA;

  always_comb begin
    if (ciRequest.dataB[0]) begin
      wordOut.halves[1] = wordIn.halves[0];  // half-word exchange.
      wordOut.halves[0] = wordIn.halves[1];
    end else begin
      wordOut.bytes[3] = wordIn.bytes[0];  // full endian swap.
      wordOut.bytes[2] = wordIn.bytes[1];
      wordOut.bytes[1] = wordIn.bytes[2];
      wordOut.bytes[0] = wordIn.bytes[3];
    end
  end

  assign ciResponse.done = hit;
  assign ciResponse.result = hit ? wordOut : '0;  // zero keeps the wired-OR clean.

endmodule

`default_nettype wire

// File: resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ciUnit_config.svh"

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic ready
);

  logic [`RESET_COUNT_BITS-1:0] resetCount;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!resetCount[`RESET_COUNT_BITS-1]) begin
      resetCount <= resetCount + 1'b1;  // stops once the top bit sets.
    end
  end

  assign ready = resetCount[`RESET_COUNT_BITS-1];

  // only a loss of lock may take the system back into reset.
  readyStaysHigh : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
      ready |=> ready
  );

endmodule

`default_nettype wire

// File: pixelPkg.sv
`default_nettype none

package pixelPkg;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  typedef logic [7:0] gray_t;

endpackage

`default_nettype wire

// File: ciPkg.sv
`default_nettype none

package ciPkg;

  typedef logic [7:0] ciOpcode_t;
  typedef logic [31:0] ciWord_t;

  typedef struct packed {
    logic      start;  // one-cycle strobe.
    ciOpcode_t opcode;
    ciWord_t   dataA;
    ciWord_t   dataB;
  } ciRequest_t;

  typedef struct packed {
    logic    done;    // one-cycle pulse.
    ciWord_t result;  // valid only with done.
  } ciResponse_t;

  // same word seen as bytes or as half-words.
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } ciWord_u;

endpackage

`default_nettype wire

// File: ciUnit_config.svh
`ifndef CI_UNIT_CONFIG_SVH
`define CI_UNIT_CONFIG_SVH

// instruction numbers as they appear on ciRequest.opcode.
`define SWAP_BYTE_CI_ID 8'd1
`define DELAY_CI_ID 8'd6
`define PROFILE_CI_ID 8'd12
`define GRAY_CI_ID 8'd13

// ready is the top counter bit, so release takes 2**(bits-1) cycles.
`define RESET_COUNT_BITS 5

// 100 ns system clock.
`define CYCLES_PER_MICROSECOND 10

`endif
